//--- src/alut_cfg_pkg.sv
/*
 Table geometry, command codes and the age checker state encoding for the
 ALUT ageing logic. Referenced by scoped name from the RTL and the bound
 assertions.
*/

package alut_cfg_pkg;

   // -------------------------------------------------------------------
   // table geometry
   // -------------------------------------------------------------------
   typedef logic [7:0] tbl_addr_t;            // table index, low mac bits
   typedef logic [7:0] div_t;                 // clock divider setting

   localparam tbl_addr_t max_addr = 8'd255;   // last table index

   // -------------------------------------------------------------------
   // command codes and age checker states
   // -------------------------------------------------------------------
   typedef enum logic [1:0] {
      cmd_none       = 2'b00,
      cmd_rsvd       = 2'b01,                 // no action
      cmd_inval_aged = 2'b10,                 // clear all out-of-date entries
      cmd_inval_all  = 2'b11                  // clear every entry
   } alut_cmd_t;

   typedef enum logic [2:0] {
      st_idle,
      st_inval_aged_rd,                       // present next sweep address
      st_inval_aged_wr,                       // zero an aged entry
      st_inval_all,                           // one write per cycle
      st_age_chk                              // judge age, confirm result
   } age_state_t;

endpackage

//--- src/alut_entry_pkg.sv
/*
 Field types and bit positions of the 83-bit table entry.
 Entry layout from lsb: mac, port, last access time, valid.
*/

package alut_entry_pkg;

   // -------------------------------------------------------------------
   // field types
   // -------------------------------------------------------------------
   typedef logic [47:0] mac_t;    // station address
   typedef logic [1:0]  port_t;   // switch port
   typedef logic [31:0] time_t;   // time base units
   typedef logic [82:0] entry_t;  // one table word

   // -------------------------------------------------------------------
   // field positions inside entry_t
   // -------------------------------------------------------------------
   localparam int mac_lsb   = 0;
   localparam int port_lsb  = 48;
   localparam int time_lsb  = 50;  // last access time stamp
   localparam int valid_bit = 82;  // set on learn, cleared by ageing

endpackage

//--- src/alut_time_base.sv
/*
 Time base for entry ageing. pclk25 is divided by div_clk+1 and the
 result advances a free running 32-bit current time.
*/

module alut_time_base
(
   input  logic                  pclk25,
   input  logic                  n_p_reset25,
   input  alut_cfg_pkg::div_t    div_clk,    // divide by div_clk+1
   output alut_entry_pkg::time_t curr_time   // stamped into learned entries
);

   alut_cfg_pkg::div_t clk_div_cnt;          // prescaler
   logic               div_wrap;             // last count of the period

   assign div_wrap = (clk_div_cnt == div_clk);

   // prescaler counts 0 .. div_clk
   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
         clk_div_cnt <= '0;
      else if (div_wrap)
         clk_div_cnt <= '0;
      else
         clk_div_cnt <= clk_div_cnt + 1'b1;
   end

   // one tick per prescaler period, wraps modulo 2^32
   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
         curr_time <= '0;
      else if (div_wrap)
         curr_time <= curr_time + 1'b1;
   end

endmodule

//--- src/alut_age_checker.sv
/*
 Age checker for the ALUT. Answers age requests from the address checker
 and runs the invalidate-aged and invalidate-all sweeps over the table.
 Keeps the last invalidated address and port plus two status bits.
*/

module alut_age_checker
(
   input  logic                      pclk25,
   input  logic                      n_p_reset25,
   input  alut_cfg_pkg::alut_cmd_t   command,
   input  logic                      check_age,        // request strobe
   input  logic                      add_check_active, // request pending
   input  alut_entry_pkg::time_t     last_accessed,    // time to judge
   input  alut_entry_pkg::time_t     best_bfr_age,
   input  alut_entry_pkg::time_t     curr_time,
   input  alut_entry_pkg::entry_t    mem_read_data,
   output alut_cfg_pkg::tbl_addr_t   mem_addr_age,
   output logic                      mem_write_age,    // data is always zero
   output logic                      age_owns_mem,
   output logic                      age_confirmed,    // one cycle pulse
   output logic                      age_ok,           // in date when confirmed
   output alut_entry_pkg::mac_t      lst_inv_addr,
   output alut_entry_pkg::port_t     lst_inv_port,
   output logic                      inval_in_prog,
   output logic                      age_check_active
);

   alut_cfg_pkg::age_state_t state;
   alut_cfg_pkg::age_state_t nxt_state;
   alut_entry_pkg::time_t    ref_time;   // stamp under test
   alut_entry_pkg::time_t    elapsed;    // curr_time minus ref_time modulo 2^32
   logic                     entry_valid;
   logic                     in_date;
   logic                     last_addr;  // sweep at final index
   logic                     sweep_chk;  // st_age_chk on behalf of a sweep
   logic                     cmd_accept;
   logic                     sweep_done;

   assign entry_valid = mem_read_data[alut_entry_pkg::valid_bit];
   assign last_addr   = (mem_addr_age == alut_cfg_pkg::max_addr);
   assign sweep_chk   = (state == alut_cfg_pkg::st_age_chk) && !add_check_active;
   assign cmd_accept  = (command == alut_cfg_pkg::cmd_inval_aged) ||
                        (command == alut_cfg_pkg::cmd_inval_all);

   // -------------------------------------------------------------------
   // age judgement
   // -------------------------------------------------------------------
   // requests carry their own stamp while sweeps use the entry's time field
   assign ref_time = add_check_active ? last_accessed :
      mem_read_data[alut_entry_pkg::time_lsb +: $bits(alut_entry_pkg::time_t)];
   assign elapsed  = curr_time - ref_time;
   assign in_date  = (best_bfr_age > elapsed);

   // -------------------------------------------------------------------
   // state machine
   // -------------------------------------------------------------------
   always_comb
   begin
      nxt_state = state;
      case (state)
         alut_cfg_pkg::st_idle:
            if (command == alut_cfg_pkg::cmd_inval_aged)
               nxt_state = alut_cfg_pkg::st_inval_aged_rd;
            else if (command == alut_cfg_pkg::cmd_inval_all)
               nxt_state = alut_cfg_pkg::st_inval_all;
            else if (check_age)
               nxt_state = alut_cfg_pkg::st_age_chk;
         alut_cfg_pkg::st_inval_aged_rd:
            nxt_state = alut_cfg_pkg::st_age_chk;
         alut_cfg_pkg::st_age_chk:
            if (age_confirmed)
            begin
               if (add_check_active)
                  nxt_state = alut_cfg_pkg::st_idle;          // request answered
               else if (entry_valid && !age_ok)
                  nxt_state = alut_cfg_pkg::st_inval_aged_wr; // stale entry gets cleared
               else if (last_addr)
                  nxt_state = alut_cfg_pkg::st_idle;
               else
                  nxt_state = alut_cfg_pkg::st_inval_aged_rd;
            end
         alut_cfg_pkg::st_inval_aged_wr:
            nxt_state = last_addr ? alut_cfg_pkg::st_idle : alut_cfg_pkg::st_inval_aged_rd;
         alut_cfg_pkg::st_inval_all:
            if (last_addr)
               nxt_state = alut_cfg_pkg::st_idle;
         default:
            nxt_state = alut_cfg_pkg::st_idle;
      endcase
   end

   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
         state <= alut_cfg_pkg::st_idle;
      else
         state <= nxt_state;
   end

   // sweep address restarts at 0 on every accepted command
   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
         mem_addr_age <= '0;
      else if (state == alut_cfg_pkg::st_idle)
      begin
         if (cmd_accept)
            mem_addr_age <= '0;
      end
      else if ((state == alut_cfg_pkg::st_inval_all) ||
               (nxt_state == alut_cfg_pkg::st_inval_aged_rd))
         mem_addr_age <= mem_addr_age + 1'b1;
   end

   assign mem_write_age = (state == alut_cfg_pkg::st_inval_aged_wr) ||
                          (state == alut_cfg_pkg::st_inval_all);

   // table belongs to the sweep states and to sweep age checks
   assign age_owns_mem  = (state == alut_cfg_pkg::st_inval_aged_rd) ||
                          (state == alut_cfg_pkg::st_inval_aged_wr) ||
                          (state == alut_cfg_pkg::st_inval_all) ||
                          sweep_chk;

   // result registered on the first st_age_chk cycle only
   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else if ((state == alut_cfg_pkg::st_age_chk) && !age_confirmed)
      begin
         age_confirmed <= 1'b1;
         age_ok        <= in_date;
      end
      else
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
   end

   // -------------------------------------------------------------------
   // status and last invalidated entry
   // -------------------------------------------------------------------
   assign sweep_done = (nxt_state == alut_cfg_pkg::st_idle) &&
                       ((state == alut_cfg_pkg::st_inval_aged_wr) || sweep_chk);

   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
      begin
         lst_inv_addr  <= '0;
         lst_inv_port  <= '0;
         inval_in_prog <= 1'b0;
      end
      else
      begin
         if (state == alut_cfg_pkg::st_inval_aged_wr)
         begin
            // entry still readable before the zero write lands
            lst_inv_addr <= mem_read_data[alut_entry_pkg::mac_lsb +:
                                          $bits(alut_entry_pkg::mac_t)];
            lst_inv_port <= mem_read_data[alut_entry_pkg::port_lsb +:
                                          $bits(alut_entry_pkg::port_t)];
         end
         if (sweep_done)
            inval_in_prog <= 1'b0;
         else if (state == alut_cfg_pkg::st_inval_aged_wr)
            inval_in_prog <= 1'b1;   // first clear of the sweep
      end
   end

   assign age_check_active = (state != alut_cfg_pkg::st_idle);

endmodule

//--- src/alut_addr_checker.sv
/*
 Address checker. Learns a MAC and port into the slot given by the low
 MAC bits, and answers lookups by comparing the stored entry and asking
 the age checker whether it is still in date.
*/

module alut_addr_checker
(
   input  logic                    pclk25,
   input  logic                    n_p_reset25,
   input  logic                    learn,
   input  logic                    lookup,
   input  alut_entry_pkg::mac_t    mac,
   input  alut_entry_pkg::port_t   port,
   input  alut_entry_pkg::time_t   curr_time,
   input  alut_entry_pkg::entry_t  mem_read_data,
   input  logic                    age_confirmed,
   input  logic                    age_ok,
   input  logic                    age_check_active,
   output alut_cfg_pkg::tbl_addr_t mem_addr_add,
   output logic                    mem_write_add,
   output alut_entry_pkg::entry_t  mem_write_data_add,
   output logic                    check_age,          // one cycle strobe
   output logic                    add_check_active,
   output alut_entry_pkg::time_t   last_accessed,
   output logic                    lookup_done,        // one cycle strobe
   output logic                    lookup_hit,
   output alut_entry_pkg::port_t   lookup_port,
   output logic                    busy
);

   typedef enum logic [2:0] {a_idle, a_write, a_read, a_cmp, a_wait} add_state_t;

   add_state_t             state;
   alut_entry_pkg::mac_t   mac_r;        // latched request
   alut_entry_pkg::port_t  port_r;
   alut_entry_pkg::entry_t entry_r;      // indexed entry for compare
   alut_entry_pkg::port_t  entry_port;
   logic                   accept;
   logic                   entry_match;

   assign accept       = (state == a_idle) && !age_check_active && (learn || lookup);
   assign mem_addr_add = mac_r[$bits(alut_cfg_pkg::tbl_addr_t)-1:0];  // no hashing
   assign mem_write_add = (state == a_write);
   assign busy         = (state != a_idle) || age_check_active;

   assign entry_port  = entry_r[alut_entry_pkg::port_lsb +: $bits(alut_entry_pkg::port_t)];
   assign entry_match = entry_r[alut_entry_pkg::valid_bit] &&
      (entry_r[alut_entry_pkg::mac_lsb +: $bits(alut_entry_pkg::mac_t)] == mac_r);

   // learned word, valid with the time of the write
   always_comb
   begin
      mem_write_data_add = '0;
      mem_write_data_add[alut_entry_pkg::valid_bit] = 1'b1;
      mem_write_data_add[alut_entry_pkg::time_lsb +: $bits(alut_entry_pkg::time_t)] = curr_time;
      mem_write_data_add[alut_entry_pkg::port_lsb +: $bits(alut_entry_pkg::port_t)] = port_r;
      mem_write_data_add[alut_entry_pkg::mac_lsb +: $bits(alut_entry_pkg::mac_t)] = mac_r;
   end

   // -------------------------------------------------------------------
   // sequencer
   // -------------------------------------------------------------------
   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
      begin
         state            <= a_idle;
         check_age        <= 1'b0;
         add_check_active <= 1'b0;
         lookup_done      <= 1'b0;
         lookup_hit       <= 1'b0;
         lookup_port      <= '0;
      end
      else
      begin
         check_age   <= 1'b0;
         lookup_done <= 1'b0;
         case (state)
            a_idle:
               if (accept)
                  state <= learn ? a_write : a_read;   // learn wins a tie
            a_write:
               state <= a_idle;
            a_read:
               state <= a_cmp;
            a_cmp:
               if (entry_match)
               begin
                  check_age        <= 1'b1;   // ask for an age verdict
                  add_check_active <= 1'b1;
                  state            <= a_wait;
               end
               else
               begin
                  lookup_done <= 1'b1;        // miss, no age check needed
                  lookup_hit  <= 1'b0;
                  lookup_port <= '0;
                  state       <= a_idle;
               end
            a_wait:
               if (age_confirmed)
               begin
                  add_check_active <= 1'b0;
                  lookup_done      <= 1'b1;
                  lookup_hit       <= age_ok;
                  lookup_port      <= age_ok ? entry_port : '0;
                  state            <= a_idle;
               end
            default:
               state <= a_idle;
         endcase
      end
   end

   // request and entry payload
   always_ff @(posedge pclk25)
   begin
      if (accept)
      begin
         mac_r  <= mac;
         port_r <= port;
      end
      if (state == a_read)
         entry_r <= mem_read_data;
      if (state == a_cmp)
         last_accessed <= entry_r[alut_entry_pkg::time_lsb +: $bits(alut_entry_pkg::time_t)];
   end

endmodule

//--- src/alut_mem.sv
/*
 256-entry ALUT storage. The age checker takes the port while it owns the
 table, otherwise the address checker does. Reads are combinational,
 writes land on the clock edge.
*/

module alut_mem
(
   input  logic                    pclk25,
   input  logic                    n_p_reset25,
   input  logic                    age_owns_mem,
   input  alut_cfg_pkg::tbl_addr_t mem_addr_age,
   input  logic                    mem_write_age,
   input  alut_cfg_pkg::tbl_addr_t mem_addr_add,
   input  logic                    mem_write_add,
   input  alut_entry_pkg::entry_t  mem_write_data_add,
   output alut_entry_pkg::entry_t  mem_read_data
);

   alut_entry_pkg::entry_t  tbl [0:alut_cfg_pkg::max_addr];
   alut_cfg_pkg::tbl_addr_t addr;     // selected port
   logic                    wr;
   alut_entry_pkg::entry_t  wdata;

   // port select, age checker only ever clears
   assign addr  = age_owns_mem ? mem_addr_age : mem_addr_add;
   assign wr    = age_owns_mem ? mem_write_age : mem_write_add;
   assign wdata = age_owns_mem ? '0 : mem_write_data_add;

   // all entries start invalid
   always_ff @(posedge pclk25 or negedge n_p_reset25)
   begin
      if (!n_p_reset25)
      begin
         for (int i = 0; i <= alut_cfg_pkg::max_addr; i++)
            tbl[i] <= '0;
      end
      else if (wr)
         tbl[addr] <= wdata;
   end

   assign mem_read_data = tbl[addr];

endmodule

//--- src/alut_top.sv
/*
 ALUT ageing top level. Joins the time base, age checker, address checker
 and table. Register settings and commands come in as plain inputs.
*/

module alut_top
(
   input  logic                    pclk25,
   input  logic                    n_p_reset25,
   input  alut_cfg_pkg::alut_cmd_t command,
   input  alut_cfg_pkg::div_t      div_clk,
   input  alut_entry_pkg::time_t   best_bfr_age,
   input  logic                    learn,
   input  logic                    lookup,
   input  alut_entry_pkg::mac_t    mac,
   input  alut_entry_pkg::port_t   port,
   output alut_entry_pkg::time_t   curr_time,
   output logic                    lookup_done,
   output logic                    lookup_hit,
   output alut_entry_pkg::port_t   lookup_port,
   output alut_entry_pkg::mac_t    lst_inv_addr,
   output alut_entry_pkg::port_t   lst_inv_port,
   output logic                    inval_in_prog,
   output logic                    age_check_active,
   output logic                    busy
);

   // ---------------------------------------------------------------------
   // internal nets
   // ---------------------------------------------------------------------
   alut_cfg_pkg::tbl_addr_t mem_addr_age;
   alut_cfg_pkg::tbl_addr_t mem_addr_add;
   alut_entry_pkg::entry_t  mem_read_data;
   alut_entry_pkg::entry_t  mem_write_data_add;
   alut_entry_pkg::time_t   last_accessed;
   logic                    mem_write_age;
   logic                    mem_write_add;
   logic                    age_owns_mem;
   logic                    check_age;
   logic                    add_check_active;
   logic                    age_confirmed;
   logic                    age_ok;

   alut_time_base i_time_base
   (
      .pclk25(pclk25), .n_p_reset25(n_p_reset25),
      .div_clk(div_clk), .curr_time(curr_time)
   );

   alut_age_checker i_age_checker
   (
      .pclk25(pclk25), .n_p_reset25(n_p_reset25), .command(command),
      .check_age(check_age), .add_check_active(add_check_active),
      .last_accessed(last_accessed), .best_bfr_age(best_bfr_age),
      .curr_time(curr_time), .mem_read_data(mem_read_data),
      .mem_addr_age(mem_addr_age), .mem_write_age(mem_write_age),
      .age_owns_mem(age_owns_mem), .age_confirmed(age_confirmed), .age_ok(age_ok),
      .lst_inv_addr(lst_inv_addr), .lst_inv_port(lst_inv_port),
      .inval_in_prog(inval_in_prog), .age_check_active(age_check_active)
   );

   alut_addr_checker i_addr_checker
   (
      .pclk25(pclk25), .n_p_reset25(n_p_reset25), .learn(learn), .lookup(lookup),
      .mac(mac), .port(port), .curr_time(curr_time), .mem_read_data(mem_read_data),
      .age_confirmed(age_confirmed), .age_ok(age_ok),
      .age_check_active(age_check_active), .mem_addr_add(mem_addr_add),
      .mem_write_add(mem_write_add), .mem_write_data_add(mem_write_data_add),
      .check_age(check_age), .add_check_active(add_check_active),
      .last_accessed(last_accessed), .lookup_done(lookup_done),
      .lookup_hit(lookup_hit), .lookup_port(lookup_port), .busy(busy)
   );

   alut_mem i_mem
   (
      .pclk25(pclk25), .n_p_reset25(n_p_reset25), .age_owns_mem(age_owns_mem),
      .mem_addr_age(mem_addr_age), .mem_write_age(mem_write_age),
      .mem_addr_add(mem_addr_add), .mem_write_add(mem_write_add),
      .mem_write_data_add(mem_write_data_add), .mem_read_data(mem_read_data)
   );

endmodule

//--- test/alut_assertions.sv
/*
 Concurrent checks on the age checker handshake and the table write port.
 Bound into alut_age_checker and alut_mem from the testbench.
*/

module alut_assertions
(
   input logic                     pclk25,
   input logic                     n_p_reset25,
   input alut_cfg_pkg::age_state_t state,
   input logic                     age_confirmed,
   input logic                     age_ok,
   input logic                     mem_write_age,
   input logic                     age_owns_mem
);

   // -------------------------------------------------------------------
   // age request handshake
   // -------------------------------------------------------------------
   // confirm lands in the cycle after st_age_chk was entered
   confirm_after_entry: assert property (@(posedge pclk25) disable iff (!n_p_reset25)
      age_confirmed |-> (state == alut_cfg_pkg::st_age_chk) &&
                        ($past(state) == alut_cfg_pkg::st_age_chk) &&
                        ($past(state, 2) != alut_cfg_pkg::st_age_chk))
      else $error("age_confirmed outside the first st_age_chk cycle");

   ok_only_with_confirm: assert property (@(posedge pclk25) disable iff (!n_p_reset25)
      !age_confirmed |-> !age_ok)   // age_ok meaningless without confirm
      else $error("age_ok high while age_confirmed is low");

   // age checker clears only through its own port
   write_needs_owner: assert property (@(posedge pclk25) disable iff (!n_p_reset25)
      mem_write_age |-> age_owns_mem)
      else $error("mem_write_age while the age checker does not own the table");

endmodule

//--- test/tb_alut.sv
/*
 Trace-driven testbench for the ALUT ageing top level. Each line of
 test/alut_trace.txt is one operation; inputs change on the falling edge
 and results are compared with the values the trace gives.
*/

module tb_alut;

   localparam int timeout_cycles = 2000;
   localparam int tick_window    = 8;     // time base ticks per rate check
   localparam int w_idle  = 0;            // busy low
   localparam int w_done  = 1;            // lookup_done high
   localparam int w_sweep = 2;            // age_check_active low

   logic                    pclk25;
   logic                    n_p_reset25;
   alut_cfg_pkg::alut_cmd_t command;
   alut_cfg_pkg::div_t      div_clk;
   alut_entry_pkg::time_t   best_bfr_age;
   logic                    learn;
   logic                    lookup;
   alut_entry_pkg::mac_t    mac;
   alut_entry_pkg::port_t   port;
   alut_entry_pkg::time_t   curr_time;
   logic                    lookup_done;
   logic                    lookup_hit;
   alut_entry_pkg::port_t   lookup_port;
   alut_entry_pkg::mac_t    lst_inv_addr;
   alut_entry_pkg::port_t   lst_inv_port;
   logic                    inval_in_prog;
   logic                    age_check_active;
   logic                    busy;

   // -------------------------------------------------------------------
   // bookkeeping
   // -------------------------------------------------------------------
   int         errors;
   int         timeouts;
   int         checks;
   int         n_ops;
   int         fd;
   logic [7:0] op;
   logic       aborted;     // stop reading the trace
   logic       inval_seen;  // inval_in_prog seen high while waiting

   alut_top i_dut
   (
      .pclk25(pclk25), .n_p_reset25(n_p_reset25), .command(command),
      .div_clk(div_clk), .best_bfr_age(best_bfr_age), .learn(learn),
      .lookup(lookup), .mac(mac), .port(port), .curr_time(curr_time),
      .lookup_done(lookup_done), .lookup_hit(lookup_hit), .lookup_port(lookup_port),
      .lst_inv_addr(lst_inv_addr), .lst_inv_port(lst_inv_port),
      .inval_in_prog(inval_in_prog), .age_check_active(age_check_active), .busy(busy)
   );

   bind alut_age_checker alut_assertions i_age_asrt
   (
      .pclk25(pclk25), .n_p_reset25(n_p_reset25), .state(state),
      .age_confirmed(age_confirmed), .age_ok(age_ok),
      .mem_write_age(mem_write_age), .age_owns_mem(age_owns_mem)
   );

   // table side sees only the write port, handshake inputs tied off
   bind alut_mem alut_assertions i_mem_asrt
   (
      .pclk25(pclk25), .n_p_reset25(n_p_reset25), .state(alut_cfg_pkg::st_idle),
      .age_confirmed(1'b0), .age_ok(1'b0),
      .mem_write_age(mem_write_age), .age_owns_mem(age_owns_mem)
   );

   always #10 pclk25 = ~pclk25;   // period 20

   // -------------------------------------------------------------------
   // helpers
   // -------------------------------------------------------------------
   task automatic report_mismatch(input string what, input logic [63:0] got,
                                  input logic [63:0] exp);
      errors++;
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
   endtask

   function automatic logic wait_met(input int sel);
      case (sel)
         w_idle:  return !busy;
         w_done:  return lookup_done;
         default: return !age_check_active;
      endcase
   endfunction

   // polls on falling edges, gives up after timeout_cycles
   task automatic wait_until(input int sel);
      int cnt;
      cnt = 0;
      while (!aborted && !wait_met(sel))
      begin
         @(negedge pclk25);
         if (inval_in_prog)
            inval_seen = 1'b1;
         cnt++;
         if (cnt >= timeout_cycles && !wait_met(sel))
         begin
            $display("timeout at %0t: DUT did not %s within %0d cycles", $time,
                     (sel == w_done) ? "finish the lookup" :
                     (sel == w_idle) ? "become idle" : "end the sweep", cnt);
            timeouts++;
            aborted = 1'b1;
         end
      end
   endtask

   task automatic skip_line();
      int ch;
      ch = 0;
      while (ch != 10 && ch != -1)
         ch = $fgetc(fd);
   endtask

   task automatic report_bad_line(input logic [7:0] code);
      $display("trace line with opcode '%c' could not be read", code);
      aborted = 1'b1;
   endtask

   // -------------------------------------------------------------------
   // operations
   // -------------------------------------------------------------------
   // one tick per d+1 cycles, so an exact multiple window needs no phase
   task automatic set_time_base(input alut_cfg_pkg::div_t d, input alut_entry_pkg::time_t best);
      alut_entry_pkg::time_t t0;
      wait_until(w_idle);
      div_clk      = d;
      best_bfr_age = best;
      t0           = curr_time;
      repeat (tick_window * (d + 1)) @(negedge pclk25);
      checks++;
      if (curr_time !== t0 + tick_window)
         report_mismatch("curr_time", curr_time, t0 + tick_window);
   endtask

   task automatic learn_entry(input alut_entry_pkg::mac_t m, input alut_entry_pkg::port_t p);
      wait_until(w_idle);
      mac   = m;
      port  = p;
      learn = 1'b1;
      @(negedge pclk25);
      learn = 1'b0;
      wait_until(w_idle);
   endtask

   task automatic lookup_entry(input alut_entry_pkg::mac_t m, input logic exp_hit,
                               input alut_entry_pkg::port_t exp_port);
      wait_until(w_idle);
      if (aborted)
         return;
      mac    = m;
      lookup = 1'b1;
      @(negedge pclk25);
      lookup = 1'b0;
      learn  = 1'b1;               // stray learn while busy, must be dropped
      port   = ~exp_port;
      checks++;
      if (!busy)
         report_mismatch("busy during lookup", busy, 1);
      @(negedge pclk25);
      learn = 1'b0;
      wait_until(w_done);
      if (aborted)
         return;
      checks += 2;
      if (lookup_hit !== exp_hit)
         report_mismatch("lookup_hit", lookup_hit, exp_hit);
      if (lookup_port !== exp_port)
         report_mismatch("lookup_port", lookup_port, exp_port);
   endtask

   task automatic sweep_aged(input alut_entry_pkg::mac_t exp_mac,
                             input alut_entry_pkg::port_t exp_port);
      wait_until(w_idle);
      if (aborted)
         return;
      inval_seen = 1'b0;
      command    = alut_cfg_pkg::cmd_inval_aged;
      @(negedge pclk25);
      command = alut_cfg_pkg::cmd_none;
      wait_until(w_sweep);
      if (aborted)
         return;
      checks += 4;
      if (lst_inv_addr !== exp_mac)
         report_mismatch("lst_inv_addr", lst_inv_addr, exp_mac);
      if (lst_inv_port !== exp_port)
         report_mismatch("lst_inv_port", lst_inv_port, exp_port);
      if (inval_in_prog !== 1'b0)
         report_mismatch("inval_in_prog after sweep", inval_in_prog, 0);
      if (inval_seen !== (exp_mac != '0))
         report_mismatch("inval_in_prog raised", inval_seen, exp_mac != '0);
   endtask

   task automatic clear_all();
      wait_until(w_idle);
      command = alut_cfg_pkg::cmd_inval_all;
      @(negedge pclk25);
      command = alut_cfg_pkg::cmd_none;
      wait_until(w_idle);
   endtask

   task automatic run_op(input logic [7:0] code);
      logic [63:0] f1;
      logic [63:0] f2;
      logic [63:0] f3;
      case (code)
         "#": skip_line();
         "S":
            if ($fscanf(fd, " %h %h", f1, f2) == 2)
               set_time_base(f1[7:0], f2[31:0]);
            else
               report_bad_line(code);
         "L":
            if ($fscanf(fd, " %h %h", f1, f2) == 2)
               learn_entry(f1[47:0], f2[1:0]);
            else
               report_bad_line(code);
         "Q":
            if ($fscanf(fd, " %h %h %h", f1, f2, f3) == 3)
               lookup_entry(f1[47:0], f2[0], f3[1:0]);
            else
               report_bad_line(code);
         "T":
            if ($fscanf(fd, " %h", f1) == 1)
               repeat (f1[15:0]) @(negedge pclk25);   // idle, time base runs on
            else
               report_bad_line(code);
         "A":
            if ($fscanf(fd, " %h %h", f1, f2) == 2)
               sweep_aged(f1[47:0], f2[1:0]);
            else
               report_bad_line(code);
         "C": clear_all();
         default: report_bad_line(code);
      endcase
   endtask

   // -------------------------------------------------------------------
   // main sequence
   // -------------------------------------------------------------------
   initial
   begin
      pclk25       = 1'b0;
      n_p_reset25  = 1'b0;
      command      = alut_cfg_pkg::cmd_none;
      div_clk      = '0;
      best_bfr_age = '0;
      learn        = 1'b0;
      lookup       = 1'b0;
      mac          = '0;
      port         = '0;
      errors       = 0;
      timeouts     = 0;
      checks       = 0;
      n_ops        = 0;
      aborted      = 1'b0;
      inval_seen   = 1'b0;
      repeat (8) @(posedge pclk25);
      @(negedge pclk25);
      n_p_reset25 = 1'b1;

      fd = $fopen("test/alut_trace.txt", "r");
      if (fd == 0)
      begin
         $display("could not open test/alut_trace.txt");
         aborted = 1'b1;
      end
      while (!aborted && $fscanf(fd, " %c", op) == 1)
      begin
         if (op != "#")
            n_ops++;
         run_op(op);
      end
      if (fd != 0)
         $fclose(fd);
      if (n_ops == 0)
         $display("no operations were read from the trace");

      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0 && !aborted && n_ops > 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

//--- sources.f
src/alut_cfg_pkg.sv
src/alut_entry_pkg.sv
src/alut_time_base.sv
src/alut_age_checker.sv
src/alut_addr_checker.sv
src/alut_mem.sv
src/alut_top.sv
test/alut_assertions.sv
test/tb_alut.sv

//--- run_sim.sh
#!/bin/sh
# Build the ALUT testbench with Verilator, run it and judge the log.
# Exits 0 only when the testbench printed its pass line.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   -f sources.f --top-module tb_alut -o sim_alut
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_alut > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
   exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- test/alut_trace.txt
# one operation per line, numbers in hex
# S div best | L mac port | Q mac hit port | T cycles | A last_mac last_port | C
S 3 180
L 001122334455 1
Q 001122334455 1 1
Q 0a0b0c0d0e0f 0 0
Q 111122334455 0 0
Q 0a0b0c0d0e0f 0 0
L 00aa00bb0010 2
L 00aa00bb0080 3
T 800
Q 001122334455 0 0
L 00cc00dd0090 1
L 00cc00dd0020 2
A 00aa00bb0080 3
Q 00cc00dd0090 1 1
Q 00cc00dd0020 1 2
Q 00aa00bb0010 0 0
Q 00aa00bb0080 0 0
Q 001122334455 0 0
C
Q 00cc00dd0090 0 0
Q 00cc00dd0020 0 0
